//--- source/clkPkg.sv
////////////////////////////////////////////////////////////
// Diagnostic clock control definitions
////////////////////////////////////////////////////////////
package clkPkg;

  typedef logic [3:0] nibbleT;      // Data nibble of a function
  typedef logic [2:0] funcCodeT;
  typedef logic [7:0] burstCountT;
  typedef logic [1:0] rateSelT;     // One pulse every 2^r cycles
  typedef logic [7:0] diagWordT;

  typedef enum logic [1:0] {
    funcCtl,
    funcLoad,
    funcRead
  } funcGroupE;

  typedef enum logic [1:0] {
    modeStop,
    modeRun,
    modeSingle,
    modeBurst
  } gateModeE;

  // Control group
  localparam funcCodeT FUNC_STOP        = 3'd0;
  localparam funcCodeT FUNC_START       = 3'd1;
  localparam funcCodeT FUNC_SINGLE_STEP = 3'd2;
  localparam funcCodeT FUNC_BURST       = 3'd4;
  localparam funcCodeT FUNC_CLR_RESET   = 3'd6;
  localparam funcCodeT FUNC_SET_RESET   = 3'd7;

  // Load group
  localparam funcCodeT LD_BURST_LSB = 3'd2;
  localparam funcCodeT LD_BURST_MSB = 3'd3;
  localparam funcCodeT LD_RATE_SEL  = 3'd4;
  localparam funcCodeT LD_EBOX_DIS  = 3'd5;

  // Read group
  localparam funcCodeT RD_BURST  = 3'd0;
  localparam funcCodeT RD_STATUS = 3'd1;

endpackage

//--- source/diagFuncIf.sv
////////////////////////////////////////////////////////////
// Accepted diagnostic function
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface diagFuncIf import clkPkg::*; ();

  logic      strobe;   // One cycle per accepted request
  funcGroupE group;
  funcCodeT  code;
  nibbleT    data;

  // Handshake side
  modport source (
    output strobe,
    output group,
    output code,
    output data
  );

  // Consumers
  modport sink (
    input strobe,
    input group,
    input code,
    input data
  );

endinterface

//--- source/diagFuncDecoder.sv
////////////////////////////////////////////////////////////
// Diagnostic function handshake
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module diagFuncDecoder import clkPkg::*; (
  input  logic      CLK,
  input  logic      rstN,
  input  logic      funcReq,
  input  funcGroupE funcGroup,
  input  funcCodeT  funcCode,
  input  nibbleT    funcData,
  output logic      funcAck,
  diagFuncIf.source func
);

  typedef enum logic [1:0] {
    hsIdle,
    hsExec,
    hsAck,
    hsRelease
  } hsStateE;

  hsStateE state;
  hsStateE stateNext;
  logic    strobe;

  always_comb begin
    stateNext = state;
    case (state)
      hsIdle:    if (funcReq) stateNext = hsExec;
      hsExec:    stateNext = hsAck;
      hsAck:     stateNext = hsRelease;
      hsRelease: if (!funcReq) stateNext = hsIdle;
      default:   stateNext = hsIdle;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      state <= hsIdle;
      strobe <= 1'b0;
    end else begin
      state <= stateNext;
      strobe <= (state == hsExec);
    end
  end

  // Request fields, held until the next acceptance
  always_ff @(posedge CLK) begin
    if (state == hsIdle && funcReq) begin
      func.group <= funcGroup;
      func.code <= funcCode;
      func.data <= funcData;
    end
  end

  assign func.strobe = strobe;
  assign funcAck = (state == hsRelease);  // Held until funcReq drops

  // Host keeps funcReq up until it sees the ack
  ackNeedsReq: assert property (
    @(posedge CLK) disable iff (!rstN)
    $rose(funcAck) |-> $past(funcReq)
  ) else $error("funcAck rose without a pending request");

  strobeOneCycle: assert property (
    @(posedge CLK) disable iff (!rstN)
    func.strobe |=> !func.strobe
  ) else $error("strobe held for more than one cycle");

endmodule

//--- source/clkConfigRegs.sv
////////////////////////////////////////////////////////////
// Rate select and EBOX disables
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module clkConfigRegs import clkPkg::*; (
  input  logic    CLK,
  input  logic    rstN,
  diagFuncIf.sink func,
  output rateSelT rateSel,
  output logic    crmDis,
  output logic    edpDis,
  output logic    ctlDis
);

  logic ldRate;
  logic ldDis;

  assign ldRate = func.strobe && func.group == funcLoad && func.code == LD_RATE_SEL;
  assign ldDis = func.strobe && func.group == funcLoad && func.code == LD_EBOX_DIS;

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      rateSel <= '0;
      crmDis <= 1'b0;
      edpDis <= 1'b0;
      ctlDis <= 1'b0;
    end else begin
      if (ldRate) rateSel <= func.data[1:0];
      if (ldDis) begin
        crmDis <= func.data[2];
        edpDis <= func.data[1];
        ctlDis <= func.data[0];
      end
    end
  end

  // Only a host load may touch the configuration
  cfgLoadOnly: assert property (
    @(posedge CLK) disable iff (!rstN)
    !$stable({rateSel, crmDis, edpDis, ctlDis}) |->
      $past(func.strobe && func.group == funcLoad)
  ) else $error("configuration changed without a load strobe");

endmodule

//--- source/burstCounter.sv
////////////////////////////////////////////////////////////
// Burst down-counter
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module burstCounter import clkPkg::*; (
  input  logic       CLK,
  input  logic       rstN,
  diagFuncIf.sink    func,
  input  logic       decrement,
  output burstCountT count,
  output logic       countZero
);

  logic ldLsb;
  logic ldMsb;

  assign ldLsb = func.strobe && func.group == funcLoad && func.code == LD_BURST_LSB;
  assign ldMsb = func.strobe && func.group == funcLoad && func.code == LD_BURST_MSB;

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      count <= '0;
    end else if (ldLsb) begin
      count[3:0] <= func.data;
    end else if (ldMsb) begin
      count[7:4] <= func.data;
    end else if (decrement) begin
      count <= count - 8'd1;
    end
  end

  assign countZero = (count == '0);

  // Gate control must stop bursting once the count runs out
  noDecAtZero: assert property (
    @(posedge CLK) disable iff (!rstN)
    decrement |-> !countZero
  ) else $error("burst decrement with count at zero");

endmodule

//--- source/eboxGateCtl.sv
////////////////////////////////////////////////////////////
// EBOX gating mode and clock enables
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module eboxGateCtl import clkPkg::*; (
  input  logic     CLK,
  input  logic     rstN,
  diagFuncIf.sink  func,
  input  rateSelT  rateSel,
  input  logic     crmDis,
  input  logic     edpDis,
  input  logic     ctlDis,
  input  logic     countZero,
  output logic     pulse,
  output logic     eboxClkEn,
  output logic     crmClkEn,
  output logic     edpClkEn,
  output logic     ctlClkEn,
  output logic     running,
  output gateModeE mode,
  output logic     mrReset
);

  logic [2:0] prescale;
  logic       rateTick;
  logic       ctlStrobe;

  assign ctlStrobe = func.strobe && func.group == funcCtl;

  always_comb begin
    case (rateSel)
      2'd0:    rateTick = 1'b1;
      2'd1:    rateTick = (prescale[0] == 1'b0);
      2'd2:    rateTick = (prescale[1:0] == 2'b00);
      default: rateTick = (prescale == 3'b000);
    endcase
  end

  // No pulse on an exhausted burst
  assign eboxClkEn = rateTick && mode != modeStop && !mrReset &&
                     !(mode == modeBurst && countZero);
  assign pulse = eboxClkEn && mode == modeBurst;  // Burst decrement only
  assign crmClkEn = eboxClkEn & ~crmDis;
  assign edpClkEn = eboxClkEn & ~edpDis;
  assign ctlClkEn = eboxClkEn & ~ctlDis;
  assign running = (mode != modeStop);

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      prescale <= '0;
      mode <= modeStop;
      mrReset <= 1'b0;
    end else begin
      prescale <= prescale + 3'd1;  // Free running
      if (ctlStrobe) begin
        case (func.code)
          FUNC_STOP:        mode <= modeStop;
          FUNC_START:       mode <= modeRun;
          FUNC_SINGLE_STEP: mode <= modeSingle;
          FUNC_BURST:       mode <= countZero ? modeStop : modeBurst;
          FUNC_CLR_RESET:   mrReset <= 1'b1;
          FUNC_SET_RESET:   mrReset <= 1'b0;
          default:          ;
        endcase
      end else if (mode == modeSingle && eboxClkEn) begin
        mode <= modeStop;
      end else if (mode == modeBurst && countZero) begin
        mode <= modeStop;
      end
    end
  end

  singleOnePulse: assert property (
    @(posedge CLK) disable iff (!rstN)
    (eboxClkEn && mode == modeSingle) |=> (!eboxClkEn || $past(func.strobe))
  ) else $error("single step produced a second pulse");

endmodule

//--- source/diagReadMux.sv
////////////////////////////////////////////////////////////
// Diagnostic readback
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module diagReadMux import clkPkg::*; (
  input  logic       CLK,
  input  logic       rstN,
  diagFuncIf.sink    func,
  input  burstCountT count,
  input  gateModeE   mode,
  input  logic       mrReset,
  input  rateSelT    rateSel,
  input  logic       crmDis,
  input  logic       edpDis,
  input  logic       ctlDis,
  output diagWordT   readData
);

  diagWordT selWord;

  always_comb begin
    case (func.code)
      RD_BURST:  selWord = count;
      RD_STATUS: selWord = {mode, mrReset, rateSel, crmDis, edpDis, ctlDis};
      default:   selWord = '0;
    endcase
  end

  // Held for the host until the next read
  always_ff @(posedge CLK) begin
    if (!rstN) begin
      readData <= '0;
    end else if (func.strobe && func.group == funcRead) begin
      readData <= selWord;
    end
  end

endmodule

//--- source/clkTop.sv
////////////////////////////////////////////////////////////
// Diagnostic clock control core
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module clkTop import clkPkg::*; (
  input  logic      CLK,
  input  logic      rstN,
  input  logic      funcReq,
  input  funcGroupE funcGroup,
  input  funcCodeT  funcCode,
  input  nibbleT    funcData,
  output logic      funcAck,
  output diagWordT  readData,
  output logic      eboxClkEn,
  output logic      crmClkEn,
  output logic      edpClkEn,
  output logic      ctlClkEn,
  output logic      running,
  output logic      mrReset
);

  rateSelT    rateSel;
  logic       crmDis;
  logic       edpDis;
  logic       ctlDis;
  burstCountT count;
  logic       countZero;
  logic       pulse;
  gateModeE   mode;

  diagFuncIf func ();

  diagFuncDecoder decoder0 (
    .CLK       (CLK),
    .rstN      (rstN),
    .funcReq   (funcReq),
    .funcGroup (funcGroup),
    .funcCode  (funcCode),
    .funcData  (funcData),
    .funcAck   (funcAck),
    .func      (func.source)
  );

  clkConfigRegs cfg0 (
    .CLK     (CLK),
    .rstN    (rstN),
    .func    (func.sink),
    .rateSel (rateSel),
    .crmDis  (crmDis),
    .edpDis  (edpDis),
    .ctlDis  (ctlDis)
  );

  burstCounter burst0 (
    .CLK       (CLK),
    .rstN      (rstN),
    .func      (func.sink),
    .decrement (pulse),     // One per burst pulse
    .count     (count),
    .countZero (countZero)
  );

  eboxGateCtl gate0 (
    .CLK       (CLK),
    .rstN      (rstN),
    .func      (func.sink),
    .rateSel   (rateSel),
    .crmDis    (crmDis),
    .edpDis    (edpDis),
    .ctlDis    (ctlDis),
    .countZero (countZero),
    .pulse     (pulse),
    .eboxClkEn (eboxClkEn),
    .crmClkEn  (crmClkEn),
    .edpClkEn  (edpClkEn),
    .ctlClkEn  (ctlClkEn),
    .running   (running),
    .mode      (mode),
    .mrReset   (mrReset)
  );

  diagReadMux read0 (
    .CLK      (CLK),
    .rstN     (rstN),
    .func     (func.sink),
    .count    (count),
    .mode     (mode),
    .mrReset  (mrReset),
    .rateSel  (rateSel),
    .crmDis   (crmDis),
    .edpDis   (edpDis),
    .ctlDis   (ctlDis),
    .readData (readData)
  );

endmodule

//--- testbench/clkTbTasks.svh
////////////////////////////////////////////////////////////
// Host handshake and error reporting
////////////////////////////////////////////////////////////
`ifndef CLK_TB_TASKS_SVH
`define CLK_TB_TASKS_SVH

task automatic reportMismatch(input string name, input int expected, input int actual);
  errorCount++;
  $display("FAILED time=%0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
endtask

// Called 1 ns after a rising edge, returns at the same offset
task automatic waitCycles(input int n);
  repeat (n) begin
    @(posedge CLK);
    #1;
  end
endtask

// Full four-phase request, holding funcReq a few cycles past the ack
task automatic issueFunction(input funcGroupE group, input funcCodeT code, input nibbleT data);
  int edges;
  funcGroup = group;
  funcCode = code;
  funcData = data;
  funcReq = 1'b1;
  edges = 0;
  while (!funcAck && edges < 8) begin
    @(posedge CLK);
    #1;
    edges++;
  end
  if (!funcAck) begin
    errorCount++;
    $display("Handshake timeout: no funcAck for group %0d code %0d", group, code);
  end else if (edges != 3) begin
    reportMismatch("funcAck latency", 2, edges - 1);
  end
  repeat (ackHold) begin
    @(posedge CLK);
    #1;
    if (!funcAck) reportMismatch("funcAck during hold", 1, 0);
  end
  funcReq = 1'b0;
  @(posedge CLK);
  #1;
  if (funcAck) reportMismatch("funcAck after release", 0, 1);
endtask

`endif

//--- testbench/clkTopTb.sv
////////////////////////////////////////////////////////////
// Diagnostic clock control testbench
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module clkTopTb import clkPkg::*; ();

  typedef struct {
    funcGroupE group;
    funcCodeT  code;
    nibbleT    data;
    bit        checkRead;
    diagWordT  expRead;
    int        window;
    int        expPulses;   // -1 skips
    int        expSpacing;  // 0 skips
    int        expRunning;  // -1 skips
  } stimEntryT;

  localparam int ackHold = 2;

  logic CLK = 1'b0;
  logic rstN;
  logic funcReq;
  funcGroupE funcGroup;
  funcCodeT funcCode;
  nibbleT funcData;
  logic funcAck;
  diagWordT readData;
  logic eboxClkEn, crmClkEn, edpClkEn, ctlClkEn;
  logic running;
  logic mrReset;

  stimEntryT stimTable[$];
  int errorCount = 0;
  int enTotal [4] = '{default: 0};  // ebox, crm, edp, ctl
  int cycleNum = 0;
  int windowStart = 0;
  int prevPulse = 0;
  bit havePrev = 1'b0;
  int minSpace = 0;
  int maxSpace = 0;
  int spaceWindow = -1;
  int watchLimit = 0;
  bit tableReady = 1'b0;

  always #5 CLK = ~CLK;

  clkTop dut0 (.*);

  `include "clkTbTasks.svh"

  // Enables are stable at the falling edge
  always @(negedge CLK) begin
    cycleNum++;
    if (eboxClkEn) begin
      enTotal[0]++;
      if (havePrev && prevPulse > windowStart) begin
        if (spaceWindow != windowStart) begin
          minSpace = cycleNum - prevPulse;
          maxSpace = minSpace;
          spaceWindow = windowStart;
        end else begin
          if (cycleNum - prevPulse < minSpace) minSpace = cycleNum - prevPulse;
          if (cycleNum - prevPulse > maxSpace) maxSpace = cycleNum - prevPulse;
        end
      end
      havePrev = 1'b1;
      prevPulse = cycleNum;
    end
    if (crmClkEn) enTotal[1]++;
    if (edpClkEn) enTotal[2]++;
    if (ctlClkEn) enTotal[3]++;
  end

  function automatic void appendEntry(funcGroupE g, funcCodeT c, nibbleT d, bit chk,
                                      diagWordT rd, int win, int pul, int sp, int run);
    stimTable.push_back(stimEntryT'{g, c, d, chk, rd, win, pul, sp, run});
  endfunction

  function automatic void loadEntry(funcCodeT c, nibbleT d);
    appendEntry(funcLoad, c, d, 1'b0, 8'h00, 0, -1, 0, -1);
  endfunction

  function automatic void readEntry(funcCodeT c, diagWordT rd, int win, int pul, int run);
    appendEntry(funcRead, c, 4'h0, 1'b1, rd, win, pul, 0, run);
  endfunction

  function automatic void controlEntry(funcCodeT c, int win, int pul, int sp, int run);
    appendEntry(funcCtl, c, 4'h0, 1'b0, 8'h00, win, pul, sp, run);
  endfunction

  // Status layout from the top bit: mode, mrReset, rateSel, crm/edp/ctl disables
  function automatic diagWordT statusWord(gateModeE m, logic rst, rateSelT r, logic [2:0] dis);
    return {m, rst, r, dis};
  endfunction

  initial begin
    nibbleT bLo, bHi;
    rateSelT rRand;
    burstCountT burstN;
    stimEntryT e;
    int enBase [4];
    int pulses, expMasked, maxWindow;
    logic [2:0] modelDis;
    logic modelReset;
    string enName [4];
    enName = '{"eboxClkEn", "crmClkEn", "edpClkEn", "ctlClkEn"};
    rstN = 1'b0;
    funcReq = 1'b0;
    funcGroup = funcCtl;
    funcCode = '0;
    funcData = '0;
    modelDis = 3'b000;
    modelReset = 1'b0;
    void'($urandom(21743));
    bLo = nibbleT'($urandom());
    bHi = nibbleT'($urandom());
    rRand = rateSelT'($urandom());
    burstN = burstCountT'($urandom_range(31, 2));  // Two or more for a spacing

    loadEntry(LD_BURST_LSB, bLo);
    loadEntry(LD_BURST_MSB, bHi);
    readEntry(RD_BURST, {bHi, bLo}, 0, -1, 0);
    loadEntry(LD_RATE_SEL, {2'b00, rRand});
    readEntry(RD_STATUS, statusWord(modeStop, 1'b0, rRand, 3'b000), 0, -1, 0);
    readEntry(3'd5, 8'h00, 0, -1, 0);
    for (int r = 0; r < 4; r++) begin
      loadEntry(LD_RATE_SEL, nibbleT'(r));
      controlEntry(FUNC_START, 40, -1, 1 << r, 1);
      controlEntry(FUNC_STOP, 0, -1, 0, -1);
      readEntry(RD_STATUS, statusWord(modeStop, 1'b0, rateSelT'(r), 3'b000), 20, 0, 0);
    end
    loadEntry(LD_RATE_SEL, 4'd1);
    controlEntry(FUNC_SINGLE_STEP, 20, 1, 0, 0);
    loadEntry(LD_BURST_LSB, burstN[3:0]);
    loadEntry(LD_BURST_MSB, burstN[7:4]);
    controlEntry(FUNC_BURST, 2 * int'(burstN) + 20, int'(burstN), 2, 0);
    readEntry(RD_BURST, 8'h00, 0, -1, 0);
    controlEntry(FUNC_BURST, 20, 0, 0, 0);  // Count already zero
    loadEntry(LD_EBOX_DIS, 4'b0101);
    controlEntry(FUNC_START, 30, -1, 2, 1);
    controlEntry(FUNC_CLR_RESET, 0, -1, 0, 1);
    readEntry(RD_STATUS, statusWord(modeRun, 1'b1, 2'd1, 3'b101), 20, 0, 1);
    controlEntry(FUNC_SET_RESET, 30, -1, 2, 1);
    controlEntry(FUNC_STOP, 0, -1, 0, -1);
    readEntry(RD_STATUS, statusWord(modeStop, 1'b0, 2'd1, 3'b101), 20, 0, 0);

    maxWindow = 0;
    foreach (stimTable[i]) if (stimTable[i].window > maxWindow) maxWindow = stimTable[i].window;
    watchLimit = stimTable.size() * (maxWindow + 10 + ackHold) * 10 + 1000;
    tableReady = 1'b1;

    repeat (5) @(posedge CLK);
    #1;
    if ({funcAck, readData, eboxClkEn, crmClkEn, edpClkEn, ctlClkEn, running, mrReset} != '0)
      reportMismatch("outputs after reset", 0,
        int'({funcAck, readData, eboxClkEn, crmClkEn, edpClkEn, ctlClkEn, running, mrReset}));
    rstN = 1'b1;
    waitCycles(2);

    foreach (stimTable[i]) begin
      e = stimTable[i];
      windowStart = cycleNum;
      enBase = enTotal;
      issueFunction(e.group, e.code, e.data);
      if (e.checkRead && readData != e.expRead)
        reportMismatch("readData", int'(e.expRead), int'(readData));
      if (e.group == funcLoad && e.code == LD_EBOX_DIS) modelDis = e.data[2:0];
      if (e.group == funcCtl && e.code == FUNC_CLR_RESET) modelReset = 1'b1;
      if (e.group == funcCtl && e.code == FUNC_SET_RESET) modelReset = 1'b0;
      if (mrReset != modelReset) reportMismatch("mrReset", int'(modelReset), int'(mrReset));
      waitCycles(e.window);
      pulses = enTotal[0] - enBase[0];
      if (e.expPulses >= 0 && pulses != e.expPulses)
        reportMismatch("eboxClkEn pulses", e.expPulses, pulses);
      if (e.expRunning >= 0 && int'(running) != e.expRunning)
        reportMismatch("running", e.expRunning, int'(running));
      if (e.expSpacing != 0 && pulses < 2) begin
        errorCount++;
        $display("Too few eboxClkEn pulses to measure spacing in entry %0d", i);
      end else if (e.expSpacing != 0 && (minSpace != e.expSpacing || maxSpace != e.expSpacing)) begin
        reportMismatch("eboxClkEn min spacing", e.expSpacing, minSpace);
        reportMismatch("eboxClkEn max spacing", e.expSpacing, maxSpace);
      end
      for (int k = 1; k < 4; k++) begin
        expMasked = modelDis[3 - k] ? 0 : pulses;  // Bit 2 masks crm
        if (enTotal[k] - enBase[k] != expMasked)
          reportMismatch(enName[k], expMasked, enTotal[k] - enBase[k]);
      end
    end

    $display("Applied %0d entries, %0d errors", stimTable.size(), errorCount);
    if (errorCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    wait (tableReady);
    #(watchLimit);
    $display("Watchdog timeout after %0d ns, the stimulus table did not complete", watchLimit);
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- build.f
+incdir+testbench
source/clkPkg.sv
source/diagFuncIf.sv
source/diagFuncDecoder.sv
source/clkConfigRegs.sv
source/burstCounter.sv
source/eboxGateCtl.sv
source/diagReadMux.sv
source/clkTop.sv
testbench/clkTopTb.sv

//--- run.sh
#!/bin/sh
# Build and run the clkTop testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module clkTopTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/VclkTopTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi
exit 0
